// ==== hdl/ioe_cfg_pkg.sv ====
/* ioe_cfg_pkg: register map, driver modes and the control word
   shared by the configuration block and both output stages */
`default_nettype none

package ioe_cfg_pkg;

  // --------------------
  // Register map
  // --------------------
  localparam int AXI_ADDR_W = 4;                          // Two 32-bit registers
  localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR  = 4'h0;    // Control word in byte 0
  localparam logic [AXI_ADDR_W-1:0] COUNT_ADDR = 4'h4;    // Sent-word counter, read only

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // --------------------
  // Control word
  // --------------------
  typedef enum logic [1:0] {
    push_pull  = 2'd0,  // P and N both follow data
    open_drain = 2'd1,  // P held off, N pulls low
    tristate   = 2'd2   // Both transistors off
  } drive_mode_e;

  // Packed so that nfrzdrv sits in CTRL[0]
  typedef struct packed {
    drive_mode_e drive_mode;     // CTRL[6:5]
    logic        latch_open_n;   // CTRL[4] low forces the latches open
    logic        loopback_en_n;  // CTRL[3] active low
    logic        loopback_p;     // CTRL[2]
    logic        loopback_n;     // CTRL[1]
    logic        nfrzdrv;        // CTRL[0] low freezes the driver
  } out_cfg_t;

  // Clocked latches, no loopback, driver live
  localparam out_cfg_t CTRL_RESET = '{
    drive_mode:    push_pull,
    latch_open_n:  1'b1,
    loopback_en_n: 1'b1,
    loopback_p:    1'b0,
    loopback_n:    1'b0,
    nfrzdrv:       1'b1
  };

endpackage

`default_nettype wire

// ==== hdl/ioe_data_pkg.sv ====
/* ioe_data_pkg: data word and gate pair passed between the
   output pipeline stages */
`default_nettype none

package ioe_data_pkg;

  // Two data bits, sent slot0 first
  typedef struct packed {
    logic slot1;
    logic slot0;
  } tx_word_t;

  // Gate controls per slot, index is the slot
  typedef struct packed {
    logic [1:0] p;  // P transistor gates
    logic [1:0] n;  // N transistor gates
  } gate_pair_t;

endpackage

`default_nettype wire

// ==== hdl/ioe_out_cfg.sv ====
/* ioe_out_cfg: AXI4-Lite slave with the pad control register
   and a counter of words loaded into the output latches */
`timescale 1ns/1ns
`default_nettype none

module ioe_out_cfg #(
  parameter int COUNT_W = 16
) (
  input  wire                                 interpolator_clk,
  input  wire                                 arst_n,
  input  wire  [ioe_cfg_pkg::AXI_ADDR_W-1:0]  awaddr,
  input  wire                                 awvalid,
  output logic                                awready,
  input  wire  [31:0]                         wdata,
  input  wire  [3:0]                          wstrb,
  input  wire                                 wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  wire                                 bready,
  input  wire  [ioe_cfg_pkg::AXI_ADDR_W-1:0]  araddr,
  input  wire                                 arvalid,
  output logic                                arready,
  output logic [31:0]                         rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  wire                                 rready,
  input  wire                                 word_loaded,  // One real word latched
  output ioe_cfg_pkg::out_cfg_t               cfg
);

  localparam int CTRL_W = $bits(ioe_cfg_pkg::out_cfg_t);

  typedef enum logic [1:0] {
    idle,       // Waiting for address and data
    have_addr,  // Address taken, data pending
    have_data,  // Data taken, address pending
    resp        // Response held until bready
  } wr_state_e;

  wr_state_e                          wr_state;
  logic [ioe_cfg_pkg::AXI_ADDR_W-1:0] wr_addr_q;
  ioe_cfg_pkg::out_cfg_t              wr_ctrl_q;   // Byte 0 of the write data
  logic                               wr_strb0_q;
  ioe_cfg_pkg::out_cfg_t              ctrl_q;
  logic [COUNT_W-1:0]                 count_q;
  logic                               aw_hs, w_hs, b_hs, ar_hs;
  logic [31:0]                        rd_data;
  logic [1:0]                         rd_resp;

  // --------------------
  // Write channel
  // --------------------
  assign awready = (wr_state == idle) || (wr_state == have_data);
  assign wready  = (wr_state == idle) || (wr_state == have_addr);
  assign bvalid  = (wr_state == resp);
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign b_hs    = bvalid && bready;
  assign bresp   = (wr_addr_q == ioe_cfg_pkg::CTRL_ADDR || wr_addr_q == ioe_cfg_pkg::COUNT_ADDR)
                   ? ioe_cfg_pkg::RESP_OKAY : ioe_cfg_pkg::RESP_SLVERR;

  always_ff @(posedge interpolator_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= idle;
    end else begin
      case (wr_state)
        idle: begin
          if (aw_hs && w_hs) wr_state <= resp;      // Both in the same cycle
          else if (aw_hs)    wr_state <= have_addr;
          else if (w_hs)     wr_state <= have_data;
        end
        have_addr: if (w_hs)   wr_state <= resp;
        have_data: if (aw_hs)  wr_state <= resp;
        resp:      if (bready) wr_state <= idle;
        default:   wr_state <= idle;
      endcase
    end
  end

  always_ff @(posedge interpolator_clk) begin
    if (aw_hs) wr_addr_q <= awaddr;
    if (w_hs) begin
      wr_ctrl_q  <= wdata[CTRL_W-1:0];
      wr_strb0_q <= wstrb[0];                     // Upper bytes do not exist
    end
  end

  // CTRL changes on the response handshake, COUNT is never written
  always_ff @(posedge interpolator_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q  <= ioe_cfg_pkg::CTRL_RESET;
      count_q <= '0;
    end else begin
      if (b_hs && wr_strb0_q && wr_addr_q == ioe_cfg_pkg::CTRL_ADDR) ctrl_q <= wr_ctrl_q;
      if (word_loaded) count_q <= count_q + 1'b1;
    end
  end

  assign cfg = ctrl_q;

  // --------------------
  // Read channel
  // --------------------
  assign arready = !rvalid;                       // One read in flight
  assign ar_hs   = arvalid && arready;

  always_comb begin
    rd_data = '0;
    rd_resp = ioe_cfg_pkg::RESP_OKAY;
    case (araddr)
      ioe_cfg_pkg::CTRL_ADDR:  rd_data[CTRL_W-1:0]  = ctrl_q;
      ioe_cfg_pkg::COUNT_ADDR: rd_data[COUNT_W-1:0] = count_q;
      default:                 rd_resp = ioe_cfg_pkg::RESP_SLVERR;
    endcase
  end

  always_ff @(posedge interpolator_clk or negedge arst_n) begin
    if (!arst_n)     rvalid <= 1'b0;
    else if (ar_hs)  rvalid <= 1'b1;
    else if (rready) rvalid <= 1'b0;
  end

  always_ff @(posedge interpolator_clk) begin
    if (ar_hs) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  // Response stays up, with its address, until the master takes it
  bvalid_hold_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(wr_addr_q));

endmodule

`default_nettype wire

// ==== hdl/ioe_out_drive.sv ====
/* ioe_out_drive: stage 1, turns data bits into P/N gate controls
   under the drive mode and holds them in a one-entry register */
`timescale 1ns/1ns
`default_nettype none

module ioe_out_drive (
  input  wire                          interpolator_clk,
  input  wire                          arst_n,
  input  wire ioe_data_pkg::tx_word_t  tx_word,
  input  wire                          tx_valid,
  output logic                         tx_ready,
  input  wire ioe_cfg_pkg::out_cfg_t   cfg,
  output ioe_data_pkg::gate_pair_t     g_word,
  output logic                         g_valid,
  input  wire                          g_ready
);

  ioe_data_pkg::gate_pair_t gate_d;   // Mapped word before the register
  logic [1:0]               pn0, pn1; // {p, n} per slot

  // Gate pair for one bit, returned as {p, n}
  function automatic logic [1:0] map_bit(input logic d, input ioe_cfg_pkg::drive_mode_e mode);
    case (mode)
      ioe_cfg_pkg::push_pull:  map_bit = {~d, ~d};
      ioe_cfg_pkg::open_drain: map_bit = {1'b1, ~d};   // P off
      default:                 map_bit = {1'b1, 1'b0}; // Tristate, spare code too
    endcase
  endfunction

  assign pn0 = map_bit(tx_word.slot0, cfg.drive_mode);
  assign pn1 = map_bit(tx_word.slot1, cfg.drive_mode);

  always_comb begin
    gate_d.p = {pn1[1], pn0[1]};
    gate_d.n = {pn1[0], pn0[0]};
  end

  // --------------------
  // One-entry register
  // --------------------
  assign tx_ready = !g_valid || g_ready;  // Empty, or drained this cycle

  always_ff @(posedge interpolator_clk or negedge arst_n) begin
    if (!arst_n)       g_valid <= 1'b0;
    else if (tx_ready) g_valid <= tx_valid;
  end

  always_ff @(posedge interpolator_clk) begin
    if (tx_valid && tx_ready) g_word <= gate_d;  // Mode sampled at acceptance
  end

  // Stalled word holds until the latch stage takes it
  g_word_hold_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    g_valid && !g_ready |=> g_valid && $stable(g_word));

endmodule

`default_nettype wire

// ==== hdl/ioe_out_latch.sv ====
/* ioe_out_latch: stage 2, two-slot output latch sent to the pad one
   slot per cycle, with freeze, open-latch and loopback handling */
`timescale 1ns/1ns
`default_nettype none

module ioe_out_latch (
  input  wire                            interpolator_clk,
  input  wire                            arst_n,
  input  wire ioe_data_pkg::gate_pair_t  g_word,
  input  wire                            g_valid,
  output logic                           g_ready,
  input  wire ioe_cfg_pkg::out_cfg_t     cfg,
  output logic                           word_loaded,  // Real word entered the latches
  output logic                           codin_p,      // P gate +
  output logic                           codin_pb,     // P gate -
  output logic                           codin_n,      // N gate +
  output logic                           codin_nb      // N gate -
);

  logic       phase;                 // Stands in for the interpolator phases
  logic [1:0] latch_p, latch_n;      // Slot values, index is the slot
  logic       phase_d;
  logic [1:0] latch_p_d, latch_n_d;

  // --------------------
  // Phase
  // --------------------
  always_comb begin
    if (!cfg.nfrzdrv)           phase_d = phase;  // Frozen driver stops the clock
    else if (!cfg.latch_open_n) phase_d = 1'b0;   // Open latches show slot0
    else                        phase_d = ~phase;
  end

  // --------------------
  // Latch update, loopback first, then freeze
  // --------------------
  always_comb begin
    latch_p_d   = latch_p;   // Hold by default
    latch_n_d   = latch_n;
    g_ready     = 1'b0;
    word_loaded = 1'b0;
    if (!cfg.loopback_en_n) begin
      latch_p_d = {2{cfg.loopback_p}};           // Stream ignored
      latch_n_d = {2{cfg.loopback_n}};
    end else if (!cfg.nfrzdrv) begin
      g_ready = 1'b1;                            // Word consumed but not counted
      if (g_valid) begin
        latch_p_d = {2{g_word.p[1]}};            // Slot1 into both slots
        latch_n_d = {2{g_word.n[1]}};
      end
    end else begin
      g_ready = !cfg.latch_open_n || phase;      // Clocked loads on phase 1 only
      if (g_valid && g_ready) begin
        latch_p_d   = g_word.p;
        latch_n_d   = g_word.n;
        word_loaded = 1'b1;
      end
    end
  end

  // Outputs taken from next-state values so a load shows the next cycle
  always_ff @(posedge interpolator_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase    <= 1'b0;
      latch_p  <= 2'b00;
      latch_n  <= 2'b00;
      codin_p  <= 1'b0;   // Latched zeros
      codin_pb <= 1'b1;
      codin_n  <= 1'b0;
      codin_nb <= 1'b1;
    end else begin
      phase    <= phase_d;
      latch_p  <= latch_p_d;
      latch_n  <= latch_n_d;
      codin_p  <= latch_p_d[phase_d];
      codin_pb <= ~latch_p_d[phase_d];
      codin_n  <= latch_n_d[phase_d];
      codin_nb <= ~latch_n_d[phase_d];
    end
  end

  // Pairs leave complementary in every mode
  codin_pair_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    (codin_pb == ~codin_p) && (codin_nb == ~codin_n));

endmodule

`default_nettype wire

// ==== hdl/ioe_out_top.sv ====
/* ioe_out_top: pad output register path, configuration block
   beside a drive stage and a latch stage */
`timescale 1ns/1ns
`default_nettype none

module ioe_out_top #(
  parameter int COUNT_W = 16   // Width of the sent-word counter
) (
  input  wire                                 interpolator_clk,
  input  wire                                 arst_n,
  // AXI4-Lite configuration
  input  wire  [ioe_cfg_pkg::AXI_ADDR_W-1:0]  awaddr,
  input  wire                                 awvalid,
  output logic                                awready,
  input  wire  [31:0]                         wdata,
  input  wire  [3:0]                          wstrb,
  input  wire                                 wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  wire                                 bready,
  input  wire  [ioe_cfg_pkg::AXI_ADDR_W-1:0]  araddr,
  input  wire                                 arvalid,
  output logic                                arready,
  output logic [31:0]                         rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  wire                                 rready,
  // Data stream
  input  wire ioe_data_pkg::tx_word_t         tx_word,
  input  wire                                 tx_valid,
  output logic                                tx_ready,
  // Pad gate pairs
  output logic                                codin_p,
  output logic                                codin_pb,
  output logic                                codin_n,
  output logic                                codin_nb
);

  ioe_cfg_pkg::out_cfg_t    cfg;          // Control word to both stages
  ioe_data_pkg::gate_pair_t g_word;       // Stage 1 to stage 2
  logic                     g_valid;
  logic                     g_ready;
  logic                     word_loaded;  // Counted in COUNT

  // Port names match the nets here
  ioe_out_cfg #(.COUNT_W(COUNT_W)) ioe_out_cfg_inst (.*);
  ioe_out_drive ioe_out_drive_inst (.*);
  ioe_out_latch ioe_out_latch_inst (.*);

endmodule

`default_nettype wire

// ==== dv/tb_ioe_out.sv ====
/* tb_ioe_out: testbench for the pad output path, random words checked
   against a cycle model of both stages while AXI changes the control word */
`timescale 1ns/1ns
`default_nettype none

module tb_ioe_out;

  localparam int CLK_PERIOD = 100;
  localparam int N_PP       = 16;   // push_pull words
  localparam int N_MODE     = 8;    // Words per other drive mode
  localparam int N_OPEN     = 8;
  localparam int N_FRZ      = 4;
  localparam int N_WORDS    = N_PP + 2 * N_MODE + N_OPEN + N_FRZ + 2;  // Two held in loopback
  localparam int WATCHDOG_CYCLES = 200 * N_WORDS + 500;

  logic                               interpolator_clk;
  logic                               arst_n;
  logic [ioe_cfg_pkg::AXI_ADDR_W-1:0] awaddr, araddr;
  logic                               awvalid, awready, wvalid, wready;
  logic                               bvalid, bready, arvalid, arready, rvalid, rready;
  logic [31:0]                        wdata, rdata;
  logic [3:0]                         wstrb;
  logic [1:0]                         bresp, rresp;
  ioe_data_pkg::tx_word_t             tx_word;
  logic                               tx_valid, tx_ready;
  logic                               codin_p, codin_pb, codin_n, codin_nb;
  logic [3:0]                         codin_vec;

  // Reference model state
  ioe_cfg_pkg::out_cfg_t m_cfg;
  logic                  m_full;               // Drive register occupied
  logic [1:0]            m_p, m_n;             // Gates waiting in the drive register
  logic                  m_phase;
  logic [1:0]            m_slot_p, m_slot_n;   // Latched gates per slot
  logic [3:0]            m_codin;              // {p, pb, n, nb}
  logic [15:0]           m_count;
  logic [31:0]           m_rdata;
  logic [1:0]            m_rresp;
  logic                  m_g_ready, m_tx_ready;

  // AXI bookkeeping
  logic                               wr_busy, rd_busy;
  logic [ioe_cfg_pkg::AXI_ADDR_W-1:0] wr_addr;
  logic [31:0]                        wr_data;
  logic [3:0]                         wr_strb;
  logic [1:0]                         exp_bresp;
  string                              test_name;
  logic [31:0]                        lfsr;

  ioe_out_top #(.COUNT_W(16)) ioe_out_top_inst (.*);

  initial begin
    interpolator_clk = 1'b0;
    forever #(CLK_PERIOD / 2) interpolator_clk = ~interpolator_clk;
  end

  function automatic void stop_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endfunction

  function automatic string mismatch(input string what, input logic [31:0] exp,
                                     input logic [31:0] act);
    return $sformatf("Fail %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
  endfunction

  // Fibonacci LFSR, x^32+x^22+x^2+x+1
  function automatic logic rand_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  // Gates {p1, p0, n1, n0} of a word under a drive mode
  function automatic logic [3:0] gates_of(input ioe_data_pkg::tx_word_t w,
                                          input ioe_cfg_pkg::drive_mode_e mode);
    logic [1:0] inv;
    inv = ~{w.slot1, w.slot0};
    case (mode)
      ioe_cfg_pkg::push_pull:  return {inv, inv};
      ioe_cfg_pkg::open_drain: return {2'b11, inv};   // P off
      default:                 return {2'b11, 2'b00}; // Both off
    endcase
  endfunction

  // --------------------
  // Reference model
  // --------------------
  assign m_g_ready  = m_cfg.loopback_en_n && (!m_cfg.nfrzdrv || !m_cfg.latch_open_n || m_phase);
  assign m_tx_ready = !m_full || m_g_ready;
  assign exp_bresp  = (wr_addr == ioe_cfg_pkg::CTRL_ADDR || wr_addr == ioe_cfg_pkg::COUNT_ADDR)
                      ? ioe_cfg_pkg::RESP_OKAY : ioe_cfg_pkg::RESP_SLVERR;
  assign codin_vec  = {codin_p, codin_pb, codin_n, codin_nb};

  always @(posedge interpolator_clk or negedge arst_n) begin : ref_model
    logic [1:0] nxt_p, nxt_n;
    logic       nxt_phase;
    logic       take;
    if (!arst_n) begin
      m_cfg    <= ioe_cfg_pkg::CTRL_RESET;
      m_full   <= 1'b0;
      m_p      <= 2'b00;
      m_n      <= 2'b00;
      m_phase  <= 1'b0;
      m_slot_p <= 2'b00;
      m_slot_n <= 2'b00;
      m_codin  <= 4'b0101;   // Latched zeros
      m_count  <= '0;
      m_rdata  <= '0;
      m_rresp  <= ioe_cfg_pkg::RESP_OKAY;
    end else begin
      take      = m_full && m_g_ready;
      nxt_p     = m_slot_p;
      nxt_n     = m_slot_n;
      nxt_phase = m_phase;
      if (m_tx_ready) m_full <= tx_valid;
      if (tx_valid && m_tx_ready) {m_p, m_n} <= gates_of(tx_word, m_cfg.drive_mode);
      if (m_cfg.nfrzdrv) nxt_phase = m_cfg.latch_open_n ? ~m_phase : 1'b0;
      if (!m_cfg.loopback_en_n) begin
        nxt_p = {2{m_cfg.loopback_p}};
        nxt_n = {2{m_cfg.loopback_n}};
      end else if (take && !m_cfg.nfrzdrv) begin
        nxt_p = {2{m_p[1]}};          // Frozen, slot1 everywhere
        nxt_n = {2{m_n[1]}};
      end else if (take) begin
        nxt_p = m_p;
        nxt_n = m_n;
        m_count <= m_count + 16'd1;
      end
      m_phase  <= nxt_phase;
      m_slot_p <= nxt_p;
      m_slot_n <= nxt_n;
      m_codin  <= {nxt_p[nxt_phase], ~nxt_p[nxt_phase], nxt_n[nxt_phase], ~nxt_n[nxt_phase]};
      if (bvalid && bready && wr_addr == ioe_cfg_pkg::CTRL_ADDR && wr_strb[0])
        m_cfg <= ioe_cfg_pkg::out_cfg_t'(wr_data[6:0]);
      if (arvalid && arready) begin
        m_rresp <= ioe_cfg_pkg::RESP_OKAY;
        case (araddr)
          ioe_cfg_pkg::CTRL_ADDR:  m_rdata <= {25'd0, m_cfg};
          ioe_cfg_pkg::COUNT_ADDR: m_rdata <= {16'd0, m_count};
          default: begin
            m_rdata <= '0;
            m_rresp <= ioe_cfg_pkg::RESP_SLVERR;
          end
        endcase
      end
    end
  end

  // --------------------
  // Checks
  // --------------------
  codin_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    codin_vec == m_codin)
    else stop_run(mismatch("codin", $sampled(m_codin), $sampled(codin_vec)));
  tx_ready_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    tx_ready == m_tx_ready)
    else stop_run(mismatch("tx_ready", $sampled(m_tx_ready), $sampled(tx_ready)));
  rdata_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    rvalid |-> rdata == m_rdata)
    else stop_run(mismatch("rdata", $sampled(m_rdata), $sampled(rdata)));
  rresp_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    rvalid |-> rresp == m_rresp)
    else stop_run(mismatch("rresp", $sampled(m_rresp), $sampled(rresp)));
  bresp_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    bvalid |-> bresp == exp_bresp)
    else stop_run(mismatch("bresp", $sampled(exp_bresp), $sampled(bresp)));
  b_spurious_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    bvalid |-> wr_busy)
    else stop_run("Write response raised with no write in flight");
  r_spurious_a: assert property (@(posedge interpolator_clk) disable iff (!arst_n)
    rvalid |-> rd_busy)
    else stop_run("Read data raised with no read in flight");

  // --------------------
  // Bus and stream tasks
  // --------------------
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    wr_strb <= strb;
    wr_busy <= 1'b1;
    @(negedge interpolator_clk);
    while (!(awready && wready)) @(negedge interpolator_clk);
    @(posedge interpolator_clk);                // Address and data taken
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge interpolator_clk);
    while (!bvalid) @(negedge interpolator_clk);
    @(posedge interpolator_clk);                // Response taken
    bready  <= 1'b0;
    wr_busy <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    rd_busy <= 1'b1;
    @(negedge interpolator_clk);
    while (!arready) @(negedge interpolator_clk);
    @(posedge interpolator_clk);
    arvalid <= 1'b0;
    @(negedge interpolator_clk);
    while (!rvalid) @(negedge interpolator_clk);
    @(posedge interpolator_clk);                // Data checked on this edge
    rready  <= 1'b0;
    rd_busy <= 1'b0;
  endtask

  task automatic write_ctrl(input ioe_cfg_pkg::out_cfg_t c);
    axi_write(ioe_cfg_pkg::CTRL_ADDR, {25'd0, c}, 4'h1);
  endtask

  task automatic send_words(input int n);
    ioe_data_pkg::tx_word_t w;
    for (int i = 0; i < n; i++) begin
      w.slot0 = rand_bit();
      w.slot1 = rand_bit();
      tx_word  <= w;
      tx_valid <= 1'b1;
      @(negedge interpolator_clk);
      while (!tx_ready) @(negedge interpolator_clk);
      @(posedge interpolator_clk);              // Word transfers here
    end
    tx_valid <= 1'b0;
    @(negedge interpolator_clk);
    while (m_full) @(negedge interpolator_clk); // Drive register drained
    repeat (3) @(posedge interpolator_clk);     // Both slots shown
  endtask

  // Presents a word without waiting for it, stream is stalled in loopback
  task automatic hold_word(input int cycles);
    ioe_data_pkg::tx_word_t w;
    w.slot0 = rand_bit();
    w.slot1 = rand_bit();
    tx_word  <= w;
    tx_valid <= 1'b1;
    repeat (cycles) @(posedge interpolator_clk);
    tx_valid <= 1'b0;
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_run($sformatf("Timeout in %s after %0d cycles", test_name, WATCHDOG_CYCLES));
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    ioe_cfg_pkg::out_cfg_t c;
    test_name = "reset";
    lfsr      = 32'h1cb51dc7;
    arst_n    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    tx_word   = '0;
    tx_valid  = 1'b0;
    wr_busy   = 1'b0;
    rd_busy   = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    wr_strb   = '0;
    repeat (4) @(posedge interpolator_clk);
    arst_n <= 1'b1;
    @(posedge interpolator_clk);
    axi_read(ioe_cfg_pkg::CTRL_ADDR);
    axi_read(ioe_cfg_pkg::COUNT_ADDR);

    test_name = "push_pull";
    send_words(N_PP);
    axi_read(ioe_cfg_pkg::COUNT_ADDR);

    test_name = "open_drain";
    c = ioe_cfg_pkg::CTRL_RESET;
    c.drive_mode = ioe_cfg_pkg::open_drain;
    write_ctrl(c);
    send_words(N_MODE);
    test_name = "tristate";
    c.drive_mode = ioe_cfg_pkg::tristate;
    write_ctrl(c);
    send_words(N_MODE);
    axi_read(ioe_cfg_pkg::COUNT_ADDR);

    test_name = "open_latch";
    c = ioe_cfg_pkg::CTRL_RESET;
    c.latch_open_n = 1'b0;                      // One word per cycle
    write_ctrl(c);
    send_words(N_OPEN);
    axi_read(ioe_cfg_pkg::COUNT_ADDR);

    test_name = "freeze";
    c = ioe_cfg_pkg::CTRL_RESET;
    c.nfrzdrv = 1'b0;
    write_ctrl(c);
    send_words(N_FRZ);
    axi_read(ioe_cfg_pkg::COUNT_ADDR);

    test_name = "loopback";
    c = ioe_cfg_pkg::CTRL_RESET;
    c.loopback_en_n = 1'b0;
    c.loopback_p    = 1'b1;
    write_ctrl(c);
    hold_word(6);
    c.loopback_p = 1'b0;
    c.loopback_n = 1'b1;
    write_ctrl(c);
    hold_word(4);
    write_ctrl(ioe_cfg_pkg::CTRL_RESET);        // Stalled word now drains
    send_words(0);
    axi_read(ioe_cfg_pkg::COUNT_ADDR);

    test_name = "axi_errors";
    axi_write(4'h8, 32'h0000_005a, 4'hf);
    axi_read(4'h8);
    axi_write(ioe_cfg_pkg::COUNT_ADDR, 32'h0000_ffff, 4'hf);
    axi_write(ioe_cfg_pkg::CTRL_ADDR, 32'h0000_0040, 4'he);  // Byte 0 strobe off
    axi_read(ioe_cfg_pkg::COUNT_ADDR);
    axi_read(ioe_cfg_pkg::CTRL_ADDR);

    repeat (2) @(posedge interpolator_clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/ioe_cfg_pkg.sv
hdl/ioe_data_pkg.sv
hdl/ioe_out_cfg.sv
hdl/ioe_out_drive.sv
hdl/ioe_out_latch.sv
hdl/ioe_out_top.sv
dv/tb_ioe_out.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the pad output path testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ioe_out -f flist.f \
    -Mdir obj_dir -o sim_ioe_out; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ioe_out
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

echo "Simulation exited cleanly"
exit 0
